/* verilog/vdec_pkg.sv */
// Vector decode package
// Field widths, RVV opcode and function encodings, and the decoded
// operation and control types shared by the decode pipeline.
package vdec_pkg;

  localparam int INSTR_W    = 32;
  localparam int REG_ADDR_W = 5;
  localparam int FUNCT6_W   = 6;

  // major opcodes, anything non-vector folds into OTHER
  typedef enum logic [6:0] {
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111,
    VECTOR   = 7'b1010111,
    OTHER    = 7'b0000000
  } vopcode_e;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_e;

  // OPI funct6 codes
  typedef enum logic [FUNCT6_W-1:0] {
    F6_VADD   = 6'b000000,
    F6_VSUB   = 6'b000010,
    F6_VRSUB  = 6'b000011,
    F6_VMINU  = 6'b000100,
    F6_VMIN   = 6'b000101,
    F6_VMAXU  = 6'b000110,
    F6_VMAX   = 6'b000111,
    F6_VAND   = 6'b001001,
    F6_VOR    = 6'b001010,
    F6_VXOR   = 6'b001011,
    F6_VMSEQ  = 6'b011000,
    F6_VMSNE  = 6'b011001,
    F6_VMSLTU = 6'b011010,
    F6_VMSLT  = 6'b011011,
    F6_VMSLEU = 6'b011100,
    F6_VMSLE  = 6'b011101,
    F6_VMSGTU = 6'b011110,
    F6_VMSGT  = 6'b011111,
    F6_VSLL   = 6'b100101,
    F6_VSRL   = 6'b101000,
    F6_VSRA   = 6'b101001
  } vfunct6_e;

  // vector load/store width field
  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } mem_width_e;

  typedef enum logic [1:0] {
    MOP_UNIT    = 2'b00,
    MOP_STRIDED = 2'b10
  } mop_e;

  typedef enum logic [4:0] {
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR, OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_LOAD, OP_STORE, OP_CFG, BAD_OP
  } vop_e;

  typedef enum logic [1:0] {
    ARITH, LOAD_UNIT, STORE_UNIT, CFG_UNIT
  } fu_type_e;

  // ten ops, needs a 4 bit field
  typedef enum logic [3:0] {
    VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR,
    VALU_SLL, VALU_SRL, VALU_SRA, VALU_COMP, VALU_MM
  } valu_op_e;

  typedef enum logic [2:0] {
    VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT
  } vcomp_e;

  typedef enum logic [1:0] {
    SRC_V, SRC_X, SRC_I
  } operand_src_e;

  typedef enum logic [1:0] {
    NOT_CFG, VSETVLI, VSETIVLI, VSETVL
  } cfg_sel_e;

endpackage

/* verilog/vdec_fetch_latch.sv */
// Vector decode fetch latch
// Captures the instruction word on its valid strobe and splits the
// held word into typed fields for the decoder.
module vdec_fetch_latch (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic [vdec_pkg::INSTR_W-1:0]  instr,
  input  logic                          instr_valid,
  output logic                          f_valid,
  output vdec_pkg::vopcode_e            opcode,
  output vdec_pkg::vfunct3_e            funct3,
  output vdec_pkg::vfunct6_e            funct6,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vs1,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vs2,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vd,
  output logic                          vm,
  output vdec_pkg::mop_e                mop,
  output vdec_pkg::mem_width_e          mem_width,
  output logic [1:0]                    cfg_hi
);
  import vdec_pkg::*;

  logic [INSTR_W-1:0] instr_q;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) f_valid <= 1'b0;
    else        f_valid <= instr_valid;
  end

  always_ff @(posedge CLK) begin
    if (instr_valid) instr_q <= instr;
  end

  always_comb begin
    case (instr_q[6:0])
      LOAD_FP:  opcode = LOAD_FP;
      STORE_FP: opcode = STORE_FP;
      VECTOR:   opcode = VECTOR;
      default:  opcode = OTHER;
    endcase
  end

  assign funct3    = vfunct3_e'(instr_q[14:12]);
  assign funct6    = vfunct6_e'(instr_q[31:26]);
  assign mem_width = mem_width_e'(instr_q[14:12]); // shares funct3 slot
  assign mop       = mop_e'(instr_q[27:26]);
  assign vm        = instr_q[25];
  assign vs2       = instr_q[24:20];
  assign vs1       = instr_q[19:15];
  assign vd        = instr_q[11:7];
  assign cfg_hi    = instr_q[31:30];

endmodule

/* verilog/vdec_op_decode.sv */
// Vector operation decoder
// Maps opcode, funct3 and funct6 to one decoded operation, picks the
// config flavor and flags illegal encodings. Purely combinational.
module vdec_op_decode (
  input  logic                            f_valid,
  input  vdec_pkg::vopcode_e              opcode,
  input  vdec_pkg::vfunct3_e              funct3,
  input  vdec_pkg::vfunct6_e              funct6,
  input  logic [vdec_pkg::REG_ADDR_W-1:0] vs1,
  input  logic [vdec_pkg::REG_ADDR_W-1:0] vs2,
  input  logic [vdec_pkg::REG_ADDR_W-1:0] vd,
  input  logic                            vm,
  input  vdec_pkg::mop_e                  mop,
  input  vdec_pkg::mem_width_e            mem_width,
  input  logic [1:0]                      cfg_hi,
  output logic                            d_valid,
  output vdec_pkg::vop_e                  op,
  output logic                            illegal_insn,
  output vdec_pkg::cfg_sel_e              cfg_sel,
  output vdec_pkg::vfunct3_e              d_funct3,
  output vdec_pkg::mop_e                  d_mop,
  output logic [vdec_pkg::REG_ADDR_W-1:0] d_vs1,
  output logic [vdec_pkg::REG_ADDR_W-1:0] d_vs2,
  output logic [vdec_pkg::REG_ADDR_W-1:0] d_vd
);
  import vdec_pkg::*;

  logic   is_vec, form_vv, form_vx, form_vi;
  logic   all_forms, vv_vx, vx_vi;
  logic   width_ok, v0_overlap;
  vop_e   dec_op;

  assign is_vec  = (opcode == VECTOR);
  assign form_vv = (funct3 == OPIVV);
  assign form_vx = (funct3 == OPIVX);
  assign form_vi = (funct3 == OPIVI);

  assign all_forms = form_vv | form_vx | form_vi;
  assign vv_vx     = form_vv | form_vx;
  assign vx_vi     = form_vx | form_vi;

  assign width_ok = (mem_width == WIDTH8) || (mem_width == WIDTH16) ||
                    (mem_width == WIDTH32);

  // masked op writing v0 would clobber its own mask
  assign v0_overlap = !vm && (vd == '0);

  always_comb begin
    dec_op = BAD_OP;
    if (is_vec && all_forms) begin
      case (funct6)
        F6_VADD:   dec_op = OP_VADD;
        F6_VSUB:   dec_op = vv_vx ? OP_VSUB : BAD_OP;
        F6_VRSUB:  dec_op = vx_vi ? OP_VRSUB : BAD_OP;
        F6_VMINU:  dec_op = vv_vx ? OP_VMINU : BAD_OP;
        F6_VMIN:   dec_op = vv_vx ? OP_VMIN : BAD_OP;
        F6_VMAXU:  dec_op = vv_vx ? OP_VMAXU : BAD_OP;
        F6_VMAX:   dec_op = vv_vx ? OP_VMAX : BAD_OP;
        F6_VAND:   dec_op = OP_VAND;
        F6_VOR:    dec_op = OP_VOR;
        F6_VXOR:   dec_op = OP_VXOR;
        F6_VSLL:   dec_op = OP_VSLL;
        F6_VSRL:   dec_op = OP_VSRL;
        F6_VSRA:   dec_op = OP_VSRA;
        F6_VMSEQ:  dec_op = OP_VMSEQ;
        F6_VMSNE:  dec_op = OP_VMSNE;
        F6_VMSLTU: dec_op = vv_vx ? OP_VMSLTU : BAD_OP;
        F6_VMSLT:  dec_op = vv_vx ? OP_VMSLT : BAD_OP;
        F6_VMSLEU: dec_op = OP_VMSLEU;
        F6_VMSLE:  dec_op = OP_VMSLE;
        F6_VMSGTU: dec_op = vx_vi ? OP_VMSGTU : BAD_OP;
        F6_VMSGT:  dec_op = vx_vi ? OP_VMSGT : BAD_OP;
        default:   dec_op = BAD_OP;
      endcase
    end else if (is_vec && (funct3 == OPCFG)) begin
      dec_op = OP_CFG;
    end else if (opcode == LOAD_FP) begin
      dec_op = width_ok ? OP_LOAD : BAD_OP;
    end else if (opcode == STORE_FP) begin
      dec_op = width_ok ? OP_STORE : BAD_OP;
    end
  end

  // compares write a mask, stores and config don't touch vd as a vector
  always_comb begin
    op = dec_op;
    if (v0_overlap && !(dec_op inside {OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
                                       OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
                                       OP_STORE, OP_CFG})) begin
      op = BAD_OP;
    end
  end

  always_comb begin
    cfg_sel = NOT_CFG;
    if (op == OP_CFG) begin
      if (!cfg_hi[1])            cfg_sel = VSETVLI;
      else if (cfg_hi == 2'b11)  cfg_sel = VSETIVLI;
      else                       cfg_sel = VSETVL; // 10
    end
  end

  assign d_valid      = f_valid;
  assign illegal_insn = f_valid && (op == BAD_OP);
  assign d_funct3     = funct3;
  assign d_mop        = mop;
  assign d_vs1        = vs1;
  assign d_vs2        = vs2;
  assign d_vd         = vd;

endmodule

/* verilog/vdec_ctrl_gen.sv */
// Vector decode control generation
// Turns the decoded operation into unit, ALU, compare, operand source
// and enable controls, and registers them for the execute side.
module vdec_ctrl_gen (
  input  logic                            CLK,
  input  logic                            rst_n,
  input  logic                            d_valid,
  input  vdec_pkg::vop_e                  op,
  input  logic                            illegal_insn,
  input  vdec_pkg::cfg_sel_e              cfg_sel,
  input  vdec_pkg::vfunct3_e              d_funct3,
  input  vdec_pkg::mop_e                  d_mop,
  input  logic [vdec_pkg::REG_ADDR_W-1:0] d_vs1,
  input  logic [vdec_pkg::REG_ADDR_W-1:0] d_vs2,
  input  logic [vdec_pkg::REG_ADDR_W-1:0] d_vd,
  output logic                            ctrl_valid,
  output logic                            illegal_insn_q,
  output vdec_pkg::fu_type_e              fu_type,
  output vdec_pkg::valu_op_e              alu_op,
  output vdec_pkg::vcomp_e                comp_type,
  output vdec_pkg::operand_src_e          rs1_src,
  output vdec_pkg::operand_src_e          rs2_src,
  output logic                            is_signed,
  output logic                            sign_extend,
  output logic                            reg_wen,
  output logic                            scalar_rd_wen,
  output logic                            mem_ren,
  output logic                            mem_wen,
  output vdec_pkg::cfg_sel_e              cfg_sel_q,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vd_q,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vs1_q,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vs2_q
);
  import vdec_pkg::*;

  fu_type_e     fu_d;
  valu_op_e     alu_d;
  vcomp_e       comp_d;
  operand_src_e rs1_d, rs2_d;
  logic         signed_d, sext_d, is_mem, is_vop, ok;

  assign is_mem = (op == OP_LOAD) || (op == OP_STORE);
  assign is_vop = !(op inside {OP_LOAD, OP_STORE, OP_CFG, BAD_OP});
  assign ok     = d_valid && !illegal_insn;

  always_comb begin
    case (op)
      OP_LOAD:  fu_d = LOAD_UNIT;
      OP_STORE: fu_d = STORE_UNIT;
      OP_CFG:   fu_d = CFG_UNIT;
      default:  fu_d = ARITH;
    endcase
  end

  always_comb begin
    alu_d  = VALU_ADD; // address add for memory ops
    comp_d = VSEQ;
    case (op)
      OP_VSUB, OP_VRSUB:                   alu_d = VALU_SUB;
      OP_VAND:                             alu_d = VALU_AND;
      OP_VOR:                              alu_d = VALU_OR;
      OP_VXOR:                             alu_d = VALU_XOR;
      OP_VSLL:                             alu_d = VALU_SLL;
      OP_VSRL:                             alu_d = VALU_SRL;
      OP_VSRA:                             alu_d = VALU_SRA;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX: alu_d = VALU_MM;
      OP_VMSEQ:  begin alu_d = VALU_COMP; comp_d = VSEQ;  end
      OP_VMSNE:  begin alu_d = VALU_COMP; comp_d = VSNE;  end
      OP_VMSLTU: begin alu_d = VALU_COMP; comp_d = VSLTU; end
      OP_VMSLT:  begin alu_d = VALU_COMP; comp_d = VSLT;  end
      OP_VMSLEU: begin alu_d = VALU_COMP; comp_d = VSLEU; end
      OP_VMSLE:  begin alu_d = VALU_COMP; comp_d = VSLE;  end
      OP_VMSGTU: begin alu_d = VALU_COMP; comp_d = VSGTU; end
      OP_VMSGT:  begin alu_d = VALU_COMP; comp_d = VSGT;  end
      default:   alu_d = VALU_ADD;
    endcase
  end

  assign signed_d = op inside {OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX,
                               OP_VMSEQ, OP_VMSNE, OP_VMSLT, OP_VMSLE, OP_VMSGT};

  // shift amounts and the vsetivli avl are unsigned immediates
  assign sext_d = !((op inside {OP_VSLL, OP_VSRL, OP_VSRA}) || (cfg_sel == VSETIVLI));

  always_comb begin
    if (is_mem || (is_vop && d_funct3 == OPIVX) ||
        cfg_sel == VSETVLI || cfg_sel == VSETVL)
      rs1_d = SRC_X;
    else if ((is_vop && d_funct3 == OPIVI) || cfg_sel == VSETIVLI)
      rs1_d = SRC_I;
    else
      rs1_d = SRC_V;
  end

  assign rs2_d = (is_mem && d_mop == MOP_STRIDED) ? SRC_X : SRC_V; // stride in rs2

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_valid     <= 1'b0;
      illegal_insn_q <= 1'b0;
      reg_wen        <= 1'b0;
      scalar_rd_wen  <= 1'b0;
      mem_ren        <= 1'b0;
      mem_wen        <= 1'b0;
    end else begin
      ctrl_valid     <= d_valid;
      illegal_insn_q <= illegal_insn;
      reg_wen        <= ok && (is_vop || op == OP_LOAD);
      scalar_rd_wen  <= ok && (op == OP_CFG);
      mem_ren        <= ok && (op == OP_LOAD);
      mem_wen        <= ok && (op == OP_STORE);
    end
  end

  always_ff @(posedge CLK) begin
    fu_type     <= fu_d;
    alu_op      <= alu_d;
    comp_type   <= comp_d;
    rs1_src     <= rs1_d;
    rs2_src     <= rs2_d;
    is_signed   <= signed_d;
    sign_extend <= sext_d;
    cfg_sel_q   <= cfg_sel;
    vd_q        <= d_vd;
    vs1_q       <= d_vs1;
    vs2_q       <= d_vs2;
  end

endmodule

/* verilog/vector_decode_top.sv */
// Vector decode top level
// Two stage decode pipeline: fetch latch, op decode, control register.
module vector_decode_top (
  input  logic                            CLK,
  input  logic                            rst_n,
  input  logic [vdec_pkg::INSTR_W-1:0]    instr,
  input  logic                            instr_valid,
  output logic                            ctrl_valid,
  output logic                            illegal_insn,
  output vdec_pkg::fu_type_e              fu_type,
  output vdec_pkg::valu_op_e              alu_op,
  output vdec_pkg::vcomp_e                comp_type,
  output vdec_pkg::operand_src_e          rs1_src,
  output vdec_pkg::operand_src_e          rs2_src,
  output logic                            is_signed,
  output logic                            sign_extend,
  output logic                            reg_wen,
  output logic                            scalar_rd_wen,
  output logic                            mem_ren,
  output logic                            mem_wen,
  output vdec_pkg::cfg_sel_e              cfg_sel,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vd,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vs1,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vs2
);
  import vdec_pkg::*;

  logic                  f_valid, f_vm;
  vopcode_e              f_opcode;
  vfunct3_e              f_funct3;
  vfunct6_e              f_funct6;
  logic [REG_ADDR_W-1:0] f_vs1, f_vs2, f_vd;
  mop_e                  f_mop;
  mem_width_e            f_mem_width;
  logic [1:0]            f_cfg_hi;

  logic                  d_valid, d_illegal;
  vop_e                  d_op;
  cfg_sel_e              d_cfg_sel;
  vfunct3_e              d_funct3;
  mop_e                  d_mop;
  logic [REG_ADDR_W-1:0] d_vs1, d_vs2, d_vd;

  vdec_fetch_latch u_fetch (
    .CLK(CLK), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
    .f_valid(f_valid), .opcode(f_opcode), .funct3(f_funct3), .funct6(f_funct6),
    .vs1(f_vs1), .vs2(f_vs2), .vd(f_vd), .vm(f_vm), .mop(f_mop),
    .mem_width(f_mem_width), .cfg_hi(f_cfg_hi)
  );

  vdec_op_decode u_decode (
    .f_valid(f_valid), .opcode(f_opcode), .funct3(f_funct3), .funct6(f_funct6),
    .vs1(f_vs1), .vs2(f_vs2), .vd(f_vd), .vm(f_vm), .mop(f_mop),
    .mem_width(f_mem_width), .cfg_hi(f_cfg_hi),
    .d_valid(d_valid), .op(d_op), .illegal_insn(d_illegal), .cfg_sel(d_cfg_sel),
    .d_funct3(d_funct3), .d_mop(d_mop), .d_vs1(d_vs1), .d_vs2(d_vs2), .d_vd(d_vd)
  );

  vdec_ctrl_gen u_ctrl (
    .CLK(CLK), .rst_n(rst_n), .d_valid(d_valid), .op(d_op),
    .illegal_insn(d_illegal), .cfg_sel(d_cfg_sel), .d_funct3(d_funct3),
    .d_mop(d_mop), .d_vs1(d_vs1), .d_vs2(d_vs2), .d_vd(d_vd),
    .ctrl_valid(ctrl_valid), .illegal_insn_q(illegal_insn), .fu_type(fu_type),
    .alu_op(alu_op), .comp_type(comp_type), .rs1_src(rs1_src), .rs2_src(rs2_src),
    .is_signed(is_signed), .sign_extend(sign_extend), .reg_wen(reg_wen),
    .scalar_rd_wen(scalar_rd_wen), .mem_ren(mem_ren), .mem_wen(mem_wen),
    .cfg_sel_q(cfg_sel), .vd_q(vd), .vs1_q(vs1), .vs2_q(vs2)
  );

endmodule

/* tests/vdec_checker.sv */
// Vector decode checker
// Holds the expected control words pushed by the testbench, pops one on
// each ctrl_valid pulse and compares the DUT outputs and pulse timing.
module vdec_checker (
  input logic                            CLK,
  input logic                            rst_n,
  input logic                            ctrl_valid,
  input logic                            illegal_insn,
  input vdec_pkg::fu_type_e              fu_type,
  input vdec_pkg::valu_op_e              alu_op,
  input vdec_pkg::vcomp_e                comp_type,
  input vdec_pkg::operand_src_e          rs1_src,
  input vdec_pkg::operand_src_e          rs2_src,
  input logic                            is_signed,
  input logic                            sign_extend,
  input logic                            reg_wen,
  input logic                            scalar_rd_wen,
  input logic                            mem_ren,
  input logic                            mem_wen,
  input vdec_pkg::cfg_sel_e              cfg_sel,
  input logic [vdec_pkg::REG_ADDR_W-1:0] vd,
  input logic [vdec_pkg::REG_ADDR_W-1:0] vs1,
  input logic [vdec_pkg::REG_ADDR_W-1:0] vs2
);
  timeunit 1ns;
  timeprecision 1ps;
  import vdec_pkg::*;

  typedef struct packed {
    logic         ill;
    fu_type_e     fu;
    valu_op_e     alu;
    vcomp_e       comp;
    operand_src_e rs1;
    operand_src_e rs2;
    logic         sgn;
    logic         sext;
    logic [3:0]   wen;   // reg, scalar rd, mem read, mem write
    cfg_sel_e     cfg;
    logic [4:0]   vd;
    logic [4:0]   vs1;
    logic [4:0]   vs2;
  } exp_t;

  exp_t  exp_q[$];
  string name_q[$];
  int    due_q[$];
  int    cyc = 0;
  int    test_cnt = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;
  int    err_cnt = 0;

  task automatic push_expected(input string name, input logic ill, input fu_type_e fu,
                               input valu_op_e alu, input vcomp_e comp,
                               input operand_src_e rs1, input operand_src_e rs2,
                               input logic sgn, input logic sext, input logic [3:0] wen,
                               input cfg_sel_e cfg, input logic [4:0] exp_vd,
                               input logic [4:0] exp_vs1, input logic [4:0] exp_vs2);
    exp_t e;
    e.ill  = ill;
    e.fu   = fu;
    e.alu  = alu;
    e.comp = comp;
    e.rs1  = rs1;
    e.rs2  = rs2;
    e.sgn  = sgn;
    e.sext = sext;
    e.wen  = wen;
    e.cfg  = cfg;
    e.vd   = exp_vd;
    e.vs1  = exp_vs1;
    e.vs2  = exp_vs2;
    exp_q.push_back(e);
    name_q.push_back(name);
    due_q.push_back(cyc + 3); // strobe edge is cyc+1, result seen two edges later
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  function automatic int total_errors();
    return fail_cnt + err_cnt;
  endfunction

  task automatic compare_field(input string test, input string sig, input logic [31:0] got,
                               input logic [31:0] want, inout bit bad);
    if (got !== want) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h in %s", sig, got, want, test);
      bad = 1'b1;
    end
  endtask

  task automatic check_result();
    exp_t  e;
    string name;
    int    due;
    bit    bad;
    e    = exp_q.pop_front();
    name = name_q.pop_front();
    due  = due_q.pop_front();
    bad  = 1'b0;
    test_cnt++;
    if (cyc != due) begin
      $display("%s: ctrl_valid came at cycle %0d instead of cycle %0d", name, cyc, due);
      bad = 1'b1;
    end
    compare_field(name, "illegal_insn", 32'(illegal_insn), 32'(e.ill), bad);
    compare_field(name, "reg_wen", 32'(reg_wen), 32'(e.wen[3]), bad);
    compare_field(name, "scalar_rd_wen", 32'(scalar_rd_wen), 32'(e.wen[2]), bad);
    compare_field(name, "mem_ren", 32'(mem_ren), 32'(e.wen[1]), bad);
    compare_field(name, "mem_wen", 32'(mem_wen), 32'(e.wen[0]), bad);
    if (!e.ill) begin
      compare_field(name, "fu_type", 32'(fu_type), 32'(e.fu), bad);
      compare_field(name, "rs1_src", 32'(rs1_src), 32'(e.rs1), bad);
      compare_field(name, "rs2_src", 32'(rs2_src), 32'(e.rs2), bad);
      compare_field(name, "is_signed", 32'(is_signed), 32'(e.sgn), bad);
      compare_field(name, "sign_extend", 32'(sign_extend), 32'(e.sext), bad);
      compare_field(name, "cfg_sel", 32'(cfg_sel), 32'(e.cfg), bad);
      compare_field(name, "vd", 32'(vd), 32'(e.vd), bad);
      compare_field(name, "vs1", 32'(vs1), 32'(e.vs1), bad);
      compare_field(name, "vs2", 32'(vs2), 32'(e.vs2), bad);
      if (e.fu == ARITH) compare_field(name, "alu_op", 32'(alu_op), 32'(e.alu), bad);
      if (e.fu == ARITH && e.alu == VALU_COMP)
        compare_field(name, "comp_type", 32'(comp_type), 32'(e.comp), bad);
    end
    if (bad) begin
      fail_cnt++;
      $display("test %0d %s: wrong", test_cnt, name);
    end else begin
      pass_cnt++;
      $display("test %0d %s: ok", test_cnt, name);
    end
  endtask

  always @(posedge CLK) begin
    cyc = cyc + 1;
    if (!rst_n) begin
      if (ctrl_valid || reg_wen || scalar_rd_wen || mem_ren || mem_wen) begin
        $display("outputs active while reset is asserted at cycle %0d", cyc);
        err_cnt++;
      end
    end else if (ctrl_valid) begin
      if (exp_q.size() == 0) begin
        $display("ctrl_valid pulsed at cycle %0d with no instruction outstanding", cyc);
        err_cnt++;
      end else begin
        check_result();
      end
    end
  end

  task automatic report_summary();
    if (exp_q.size() != 0) begin
      $display("%0d instructions never produced ctrl_valid", exp_q.size());
      err_cnt++;
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d other errors",
             test_cnt, pass_cnt, fail_cnt, err_cnt);
  endtask

endmodule

/* tests/tb_vector_decode.sv */
// Vector decode testbench
// Drives a table of vector instructions through the decode pipeline with
// random idle gaps and hands the expected control words to the checker.
module tb_vector_decode;
  timeunit 1ns;
  timeprecision 1ps;
  import vdec_pkg::*;

  typedef struct packed {
    logic [31:0]  instr;
    logic         ill;
    fu_type_e     fu;
    valu_op_e     alu;
    vcomp_e       comp;
    operand_src_e rs1;
    operand_src_e rs2;
    logic         sgn;
    logic         sext;
    logic [3:0]   wen;   // reg, scalar rd, mem read, mem write
    cfg_sel_e     cfg;
  } case_t;

  logic                  CLK = 1'b0;
  logic                  rst_n;
  logic [INSTR_W-1:0]    instr;
  logic                  instr_valid;
  logic                  ctrl_valid, illegal_insn, is_signed, sign_extend;
  logic                  reg_wen, scalar_rd_wen, mem_ren, mem_wen;
  fu_type_e              fu_type;
  valu_op_e              alu_op;
  vcomp_e                comp_type;
  operand_src_e          rs1_src, rs2_src;
  cfg_sel_e              cfg_sel;
  logic [REG_ADDR_W-1:0] vd, vs1, vs2;

  case_t table_q[$];
  string name_q[$];

  always #10 CLK = ~CLK;

  vector_decode_top UUT (
    .CLK(CLK), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
    .ctrl_valid(ctrl_valid), .illegal_insn(illegal_insn), .fu_type(fu_type),
    .alu_op(alu_op), .comp_type(comp_type), .rs1_src(rs1_src), .rs2_src(rs2_src),
    .is_signed(is_signed), .sign_extend(sign_extend), .reg_wen(reg_wen),
    .scalar_rd_wen(scalar_rd_wen), .mem_ren(mem_ren), .mem_wen(mem_wen),
    .cfg_sel(cfg_sel), .vd(vd), .vs1(vs1), .vs2(vs2)
  );

  vdec_checker chk (
    .CLK(CLK), .rst_n(rst_n), .ctrl_valid(ctrl_valid), .illegal_insn(illegal_insn),
    .fu_type(fu_type), .alu_op(alu_op), .comp_type(comp_type), .rs1_src(rs1_src),
    .rs2_src(rs2_src), .is_signed(is_signed), .sign_extend(sign_extend),
    .reg_wen(reg_wen), .scalar_rd_wen(scalar_rd_wen), .mem_ren(mem_ren),
    .mem_wen(mem_wen), .cfg_sel(cfg_sel), .vd(vd), .vs1(vs1), .vs2(vs2)
  );

  function automatic logic [4:0] rand_reg();
    return 5'($urandom);
  endfunction

  // OP-V arithmetic form, unmasked
  function automatic logic [31:0] opi(input logic [5:0] f6, input logic [2:0] f3);
    return {f6, 1'b1, rand_reg(), rand_reg(), f3, rand_reg(), 7'b1010111};
  endfunction

  function automatic logic [31:0] mem_insn(input logic [6:0] opc, input logic [1:0] mop,
                                           input logic [2:0] width);
    return {4'b0000, mop, 1'b1, rand_reg(), rand_reg(), width, rand_reg(), opc};
  endfunction

  function automatic logic [31:0] cfg_insn(input logic [1:0] hi, input logic [9:0] mid);
    return {hi, mid, rand_reg(), 3'b111, rand_reg(), 7'b1010111};
  endfunction

  task automatic store_entry(input string name, input logic [31:0] word, input logic ill,
                             input fu_type_e fu, input valu_op_e alu, input vcomp_e comp,
                             input operand_src_e rs1, input operand_src_e rs2,
                             input logic sgn, input logic sext, input logic [3:0] wen,
                             input cfg_sel_e cfg);
    table_q.push_back('{word, ill, fu, alu, comp, rs1, rs2, sgn, sext, wen, cfg});
    name_q.push_back(name);
  endtask

  task automatic arith_case(input string name, input logic [31:0] word, input valu_op_e alu,
                            input operand_src_e rs1, input logic sgn, input logic sext);
    store_entry(name, word, 1'b0, ARITH, alu, VSEQ, rs1, SRC_V, sgn, sext, 4'b1000, NOT_CFG);
  endtask

  task automatic compare_case(input string name, input logic [31:0] word, input vcomp_e comp,
                              input operand_src_e rs1, input logic sgn);
    store_entry(name, word, 1'b0, ARITH, VALU_COMP, comp, rs1, SRC_V, sgn, 1'b1, 4'b1000,
                NOT_CFG);
  endtask

  task automatic illegal_case(input string name, input logic [31:0] word);
    store_entry(name, word, 1'b1, ARITH, VALU_ADD, VSEQ, SRC_V, SRC_V, 1'b0, 1'b0, 4'b0000,
                NOT_CFG);
  endtask

  task automatic mem_case(input string name, input logic [31:0] word, input fu_type_e fu,
                          input operand_src_e rs2, input logic [3:0] wen);
    store_entry(name, word, 1'b0, fu, VALU_ADD, VSEQ, SRC_X, rs2, 1'b0, 1'b1, wen, NOT_CFG);
  endtask

  task automatic config_case(input string name, input logic [31:0] word, input cfg_sel_e cfg,
                             input operand_src_e rs1, input logic sext);
    store_entry(name, word, 1'b0, CFG_UNIT, VALU_ADD, VSEQ, rs1, SRC_V, 1'b0, sext, 4'b0100,
                cfg);
  endtask

  task automatic build_table();
    arith_case("vadd.vv", opi(F6_VADD, OPIVV), VALU_ADD, SRC_V, 1'b1, 1'b1);
    arith_case("vadd.vx", opi(F6_VADD, OPIVX), VALU_ADD, SRC_X, 1'b1, 1'b1);
    arith_case("vadd.vi", opi(F6_VADD, OPIVI), VALU_ADD, SRC_I, 1'b1, 1'b1);
    arith_case("vsll.vi", opi(F6_VSLL, OPIVI), VALU_SLL, SRC_I, 1'b0, 1'b0);
    arith_case("vand.vv", opi(F6_VAND, OPIVV), VALU_AND, SRC_V, 1'b0, 1'b1);
    arith_case("vor.vx", opi(F6_VOR, OPIVX), VALU_OR, SRC_X, 1'b0, 1'b1);
    arith_case("vxor.vi", opi(F6_VXOR, OPIVI), VALU_XOR, SRC_I, 1'b0, 1'b1);
    arith_case("vminu.vv", opi(F6_VMINU, OPIVV), VALU_MM, SRC_V, 1'b0, 1'b1);
    arith_case("vsub.vx", opi(F6_VSUB, OPIVX), VALU_SUB, SRC_X, 1'b1, 1'b1);
    arith_case("vrsub.vi", opi(F6_VRSUB, OPIVI), VALU_SUB, SRC_I, 1'b1, 1'b1);
    arith_case("vmax.vv", opi(F6_VMAX, OPIVV), VALU_MM, SRC_V, 1'b1, 1'b1);
    arith_case("vsrl.vv", opi(F6_VSRL, OPIVV), VALU_SRL, SRC_V, 1'b0, 1'b0);
    arith_case("vsra.vx", opi(F6_VSRA, OPIVX), VALU_SRA, SRC_X, 1'b0, 1'b0);
    compare_case("vmseq.vv", opi(F6_VMSEQ, OPIVV), VSEQ, SRC_V, 1'b1);
    compare_case("vmsne.vx", opi(F6_VMSNE, OPIVX), VSNE, SRC_X, 1'b1);
    compare_case("vmsltu.vv", opi(F6_VMSLTU, OPIVV), VSLTU, SRC_V, 1'b0);
    compare_case("vmslt.vx", opi(F6_VMSLT, OPIVX), VSLT, SRC_X, 1'b1);
    compare_case("vmsleu.vi", opi(F6_VMSLEU, OPIVI), VSLEU, SRC_I, 1'b0);
    compare_case("vmsle.vv", opi(F6_VMSLE, OPIVV), VSLE, SRC_V, 1'b1);
    compare_case("vmsgtu.vx", opi(F6_VMSGTU, OPIVX), VSGTU, SRC_X, 1'b0);
    compare_case("vmsgt.vi", opi(F6_VMSGT, OPIVI), VSGT, SRC_I, 1'b1);
    illegal_case("vsub.vi", opi(F6_VSUB, OPIVI));
    illegal_case("vrsub.vv", opi(F6_VRSUB, OPIVV));
    illegal_case("vmsgt.vv", opi(F6_VMSGT, OPIVV));
    illegal_case("funct6 001100", opi(6'b001100, OPIVV));  // vrgather, not kept
    illegal_case("opmvv", opi(6'b000000, 3'b010));
    illegal_case("op opcode", {25'($urandom), 7'b0110011});
    illegal_case("load width 111", mem_insn(LOAD_FP, MOP_UNIT, 3'b111));
    mem_case("vle32.v", mem_insn(LOAD_FP, MOP_UNIT, WIDTH32), LOAD_UNIT, SRC_V, 4'b1010);
    mem_case("vsse16.v", mem_insn(STORE_FP, MOP_STRIDED, WIDTH16), STORE_UNIT, SRC_X, 4'b0001);
    mem_case("vlse8.v", mem_insn(LOAD_FP, MOP_STRIDED, WIDTH8), LOAD_UNIT, SRC_X, 4'b1010);
    config_case("vsetvli", cfg_insn(2'b00, 10'h0d0), VSETVLI, SRC_X, 1'b1);
    config_case("vsetvli bit30", cfg_insn(2'b01, 10'h0d0), VSETVLI, SRC_X, 1'b1);
    config_case("vsetivli", cfg_insn(2'b11, 10'h0d0), VSETIVLI, SRC_I, 1'b0);
    config_case("vsetvl", cfg_insn(2'b10, {5'd0, rand_reg()}), VSETVL, SRC_X, 1'b1);
  endtask

  task automatic apply_entry(input int idx);
    case_t c;
    c = table_q[idx];
    instr = c.instr;
    instr_valid = 1'b1;
    chk.push_expected(name_q[idx], c.ill, c.fu, c.alu, c.comp, c.rs1, c.rs2, c.sgn, c.sext,
                      c.wen, c.cfg, c.instr[11:7], c.instr[19:15], c.instr[24:20]);
  endtask

  initial begin
    int gap;
    void'($urandom(93));
    rst_n = 1'b0;
    instr = '0;
    instr_valid = 1'b0;
    build_table();
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    for (int i = 0; i < table_q.size(); i++) begin
      @(negedge CLK);
      apply_entry(i);
      gap = $urandom % 3;
      repeat (gap) begin
        @(negedge CLK);
        instr_valid = 1'b0;
        instr = $urandom;  // ignored without the strobe
      end
    end
    @(negedge CLK);
    instr_valid = 1'b0;
    while (chk.pending() != 0) @(posedge CLK);
    repeat (3) @(posedge CLK); // catch a stray pulse
    chk.report_summary();
    if (chk.total_errors() == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // watchdog, each entry takes at most three cycles
  initial begin
    int limit;
    int cycles;
    cycles = 0;
    @(posedge CLK);
    limit = 3 * table_q.size() + 20;
    while (cycles < limit) begin
      @(posedge CLK);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* vector_decode.f */
verilog/vdec_pkg.sv
verilog/vdec_fetch_latch.sv
verilog/vdec_op_decode.sv
verilog/vdec_ctrl_gen.sv
verilog/vector_decode_top.sv
tests/vdec_checker.sv
tests/tb_vector_decode.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the vector decode testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vector_decode.f --top-module tb_vector_decode \
  --Mdir obj_dir -o vector_decode_sim

./obj_dir/vector_decode_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1
